// File: source/hangmanPkg.sv
`default_nettype none

package hangmanPkg;

    // -------------------
    // game constants
    // -------------------
    localparam int WORD_LEN     = 5;
    localparam int LETTER_W     = 8;
    localparam int MAX_MISTAKES = 6;
    localparam int MISS_W       = 3;

    localparam int BUS_W  = 32;
    localparam int ADDR_W = 3;

    // status register layout. Bits above ST_MASK_HI read as zero.
    localparam int ST_BUSY    = 0;
    localparam int ST_WON     = 1;
    localparam int ST_LOST    = 2;
    localparam int ST_MISS_LO = 3;
    localparam int ST_MISS_HI = 5;
    localparam int ST_MASK_LO = 6;
    localparam int ST_MASK_HI = 10;

    // -------------------
    // encodings
    // -------------------
    typedef enum logic [ADDR_W-1:0] {
        ADDR_LETTER0 = 3'd0,
        ADDR_LETTER1 = 3'd1,
        ADDR_LETTER2 = 3'd2,
        ADDR_LETTER3 = 3'd3,
        ADDR_LETTER4 = 3'd4,
        ADDR_START   = 3'd5,
        ADDR_GUESS   = 3'd6,
        ADDR_STATUS  = 3'd7
    } wbAddr_t;

    typedef enum logic [2:0] {
        IDLE, SCAN0, SCAN1, SCAN2, SCAN3, SCAN4, REPORT
    } gameState_t;

endpackage

`default_nettype wire

// File: source/hangmanIf.sv
`timescale 1ns/1ps
`default_nettype none

// guess traffic from the bus port to the comparison FSM.
interface guessIf import hangmanPkg::*; ();
    logic                              guessValid;
    logic                              guessReady;
    logic [LETTER_W-1:0]               guessLetter;
    logic [WORD_LEN-1:0][LETTER_W-1:0] secretWord;
    logic                              newGame;

    modport port (
        output guessValid, guessLetter, secretWord, newGame,
        input  guessReady
    );

    // "logic" is reserved, so the consuming side gets this name.
    modport logicSide (
        input  guessValid, guessLetter, secretWord, newGame,
        output guessReady
    );
endinterface

// per-guess result from the FSM to the score stage.
interface resultIf import hangmanPkg::*; ();
    logic                resultValid;
    logic [WORD_LEN-1:0] hitMask;
    logic                clearScore;

    modport source (output resultValid, hitMask, clearScore);
    modport sink   (input  resultValid, hitMask, clearScore);
endinterface

`default_nettype wire

// File: source/wbGuessPort.sv
`timescale 1ns/1ps
`default_nettype none

module wbGuessPort import hangmanPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [ADDR_W-1:0]   wbAdr,
    input  logic [BUS_W-1:0]    wbDatIn,
    output logic [BUS_W-1:0]    wbDatOut,
    output logic                wbAck,
    input  logic                busy,
    input  logic                won,
    input  logic                lost,
    input  logic [MISS_W-1:0]   mistakes,
    input  logic [WORD_LEN-1:0] revealed,
    guessIf.port                gIf
);
    wbAddr_t                           addr;
    logic                              req;
    logic                              canAck;
    logic                              wrEn;
    logic                              running;
    logic                              bufFull;
    logic                              newGamePulse;
    logic [WORD_LEN-1:0][LETTER_W-1:0] word;
    logic [LETTER_W-1:0]               guessBuf;
    logic [BUS_W-1:0]                  statusWord;

    assign addr   = wbAddr_t'(wbAdr);
    assign req    = wbCyc && wbStb && !wbAck;
    // a guess waits until the buffer has drained, everything else is answered at once.
    assign canAck = (addr != ADDR_GUESS) || !bufFull;
    assign wrEn   = wbAck && wbCyc && wbStb && wbWe;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= req && canAck;
        end
    end

    // --------------------
    // game control
    // --------------------
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            running      <= 1'b0;
            bufFull      <= 1'b0;
            newGamePulse <= 1'b0;
        end else begin
            newGamePulse <= wrEn && (addr == ADDR_START);
            if (wrEn && (addr == ADDR_START)) begin
                running <= 1'b1;
                bufFull <= 1'b0;
            end else begin
                // won and lost still hold the old game for the cycle of the pulse.
                if ((won || lost) && !newGamePulse) begin
                    running <= 1'b0;
                end
                if (wrEn && (addr == ADDR_GUESS) && running) begin
                    bufFull <= 1'b1;
                end else if (bufFull && gIf.guessReady) begin
                    bufFull <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            case (addr)
                ADDR_LETTER0, ADDR_LETTER1, ADDR_LETTER2, ADDR_LETTER3, ADDR_LETTER4: begin
                    if (!running) begin
                        word[wbAdr] <= wbDatIn[LETTER_W-1:0];
                    end
                end
                ADDR_GUESS: begin
                    if (running) begin
                        guessBuf <= wbDatIn[LETTER_W-1:0];
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        statusWord                        = '0;
        statusWord[ST_BUSY]               = busy || bufFull;
        statusWord[ST_WON]                = won;
        statusWord[ST_LOST]               = lost;
        statusWord[ST_MISS_HI:ST_MISS_LO] = mistakes;
        statusWord[ST_MASK_HI:ST_MASK_LO] = revealed;
    end

    assign wbDatOut = (wbAck && !wbWe && (addr == ADDR_STATUS)) ? statusWord : '0;

    assign gIf.guessValid  = bufFull;
    assign gIf.guessLetter = guessBuf;
    assign gIf.secretWord  = word;
    assign gIf.newGame     = newGamePulse;

endmodule

`default_nettype wire

// File: source/gameLogic.sv
`timescale 1ns/1ps
`default_nettype none

module gameLogic import hangmanPkg::*; (
    input  logic      clk,
    input  logic      nRst,
    guessIf.logicSide gIf,
    resultIf.source   rIf,
    output logic      busy
);
    gameState_t                  state;
    gameState_t                  nextState;
    logic [LETTER_W-1:0]         guessHold;
    logic [WORD_LEN-1:0]         mask;
    logic                        scanning;
    logic [$clog2(WORD_LEN)-1:0] scanIdx;
    logic                        accept;

    assign accept = (state == IDLE) && gIf.guessValid;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= IDLE;
        end else if (gIf.newGame) begin
            // a fresh game abandons any scan still in flight.
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        scanning  = 1'b0;
        scanIdx   = '0;
        case (state)
            IDLE: begin
                if (gIf.guessValid) begin
                    nextState = SCAN0;
                end
            end
            SCAN0: begin
                scanning  = 1'b1;
                scanIdx   = 3'd0;
                nextState = SCAN1;
            end
            SCAN1: begin
                scanning  = 1'b1;
                scanIdx   = 3'd1;
                nextState = SCAN2;
            end
            SCAN2: begin
                scanning  = 1'b1;
                scanIdx   = 3'd2;
                nextState = SCAN3;
            end
            SCAN3: begin
                scanning  = 1'b1;
                scanIdx   = 3'd3;
                nextState = SCAN4;
            end
            SCAN4: begin
                scanning  = 1'b1;
                scanIdx   = 3'd4;
                nextState = REPORT;
            end
            REPORT: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // --------------------
    // letter comparison
    // --------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            guessHold <= gIf.guessLetter;
            mask      <= '0;
        end else if (scanning) begin
            mask[scanIdx] <= (guessHold == gIf.secretWord[scanIdx]);
        end
    end

    assign gIf.guessReady  = (state == IDLE);
    assign busy            = (state != IDLE);
    assign rIf.resultValid = (state == REPORT);
    assign rIf.hitMask     = mask;
    assign rIf.clearScore  = gIf.newGame;

endmodule

`default_nettype wire

// File: source/scoreKeeper.sv
`timescale 1ns/1ps
`default_nettype none

module scoreKeeper import hangmanPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    resultIf.sink               rIf,
    output logic                won,
    output logic                lost,
    output logic [MISS_W-1:0]   mistakes,
    output logic [WORD_LEN-1:0] revealed
);
    logic                gameOver;
    logic [WORD_LEN-1:0] nextReveal;
    logic [MISS_W-1:0]   nextMiss;

    assign gameOver   = won || lost;
    assign nextReveal = revealed | rIf.hitMask;
    assign nextMiss   = mistakes + 1'b1;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            won      <= 1'b0;
            lost     <= 1'b0;
            mistakes <= '0;
            revealed <= '0;
        end else if (rIf.clearScore) begin
            won      <= 1'b0;
            lost     <= 1'b0;
            mistakes <= '0;
            revealed <= '0;
        end else if (rIf.resultValid && !gameOver) begin
            if (rIf.hitMask != '0) begin
                revealed <= nextReveal;
                if (nextReveal == {WORD_LEN{1'b1}}) begin
                    won <= 1'b1;
                end
            end else begin
                // a guess that hits no position costs one mistake.
                mistakes <= nextMiss;
                if (nextMiss == MISS_W'(MAX_MISTAKES)) begin
                    lost <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/hangmanTop.sv
`timescale 1ns/1ps
`default_nettype none

module hangmanTop import hangmanPkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [ADDR_W-1:0]   wbAdr,
    input  logic [BUS_W-1:0]    wbDatIn,
    output logic [BUS_W-1:0]    wbDatOut,
    output logic                wbAck,
    output logic                busy,
    output logic                won,
    output logic                lost,
    output logic [MISS_W-1:0]   mistakes,
    output logic [WORD_LEN-1:0] revealed
);
    guessIf  gIf ();
    resultIf rIf ();

    wbGuessPort uWbPort (
        .clk      (clk),
        .nRst     (nRst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatIn  (wbDatIn),
        .wbDatOut (wbDatOut),
        .wbAck    (wbAck),
        .busy     (busy),
        .won      (won),
        .lost     (lost),
        .mistakes (mistakes),
        .revealed (revealed),
        .gIf      (gIf)
    );

    gameLogic uGameLogic (
        .clk  (clk),
        .nRst (nRst),
        .gIf  (gIf),
        .rIf  (rIf),
        .busy (busy)
    );

    scoreKeeper uScoreKeeper (
        .clk      (clk),
        .nRst     (nRst),
        .rIf      (rIf),
        .won      (won),
        .lost     (lost),
        .mistakes (mistakes),
        .revealed (revealed)
    );

endmodule

`default_nettype wire

// File: verification/hangman_chk.sv
`timescale 1ns/1ps
`default_nettype none

module hangmanChk (
    input logic clk,
    input logic nRst,
    input logic wbAck,
    input logic guessValid,
    input logic guessReady,
    input logic resultValid
);
    // one result pulse per scanned guess.
    resultPulse: assert property (@(posedge clk) disable iff (!nRst)
        resultValid |=> !resultValid)
        else $error("resultValid stayed high for two cycles");

    // the scan of five letters ends in a result six cycles after the guess was taken.
    scanLatency: assert property (@(posedge clk) disable iff (!nRst)
        resultValid |-> $past(guessValid && guessReady, 6))
        else $error("resultValid did not follow an accepted guess by six cycles");

    // a classic slave answers each strobe with a single ack.
    ackPulse: assert property (@(posedge clk) disable iff (!nRst)
        wbAck |=> !wbAck)
        else $error("wbAck stayed high for two cycles");
endmodule

bind hangmanTop hangmanChk uChk (
    .clk         (clk),
    .nRst        (nRst),
    .wbAck       (wbAck),
    .guessValid  (gIf.guessValid),
    .guessReady  (gIf.guessReady),
    .resultValid (rIf.resultValid)
);

`default_nettype wire

// File: verification/hangmanTb.sv
`timescale 1ns/1ps
`default_nettype none

module hangmanTb import hangmanPkg::*; ();
    localparam int NUM_GAMES    = 8;
    localparam int GUESS_CAP    = 16;
    localparam int GUESS_BUDGET = NUM_GAMES * (GUESS_CAP + MAX_MISTAKES) + 64;
    localparam int CYCLE_LIMIT  = GUESS_BUDGET * 20 + 1000;

    logic                clk;
    logic                nRst;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    logic [ADDR_W-1:0]   wbAdr;
    logic [BUS_W-1:0]    wbDatIn;
    logic [BUS_W-1:0]    wbDatOut;
    logic                wbAck;
    logic                busy;
    logic                won;
    logic                lost;
    logic [MISS_W-1:0]   mistakes;
    logic [WORD_LEN-1:0] revealed;

    integer              seed;
    int                  errors;
    int                  checks;
    int                  cycles;
    logic [LETTER_W-1:0] mWord [WORD_LEN];
    logic [WORD_LEN-1:0] mReveal;
    int                  mMiss;
    logic                mWon;
    logic                mLost;
    logic                mRunning;

    hangmanTop DUT (.*);

    always #5 clk = ~clk;

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int randBelow(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [WORD_LEN-1:0][LETTER_W-1:0] randWord();
        logic [WORD_LEN-1:0][LETTER_W-1:0] w;
        // a small alphabet makes repeated letters common.
        for (int i = 0; i < WORD_LEN; i++) begin
            w[i] = LETTER_W'(8'h61 + randBelow(8));
        end
        return w;
    endfunction

    function automatic logic [LETTER_W-1:0] pickGuess();
        if (randBelow(4) != 0) begin
            return mWord[randBelow(WORD_LEN)];
        end
        return LETTER_W'(8'h61 + randBelow(26));
    endfunction

    task automatic checkValue(input string name, input logic [BUS_W-1:0] got,
                              input logic [BUS_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // bus tasks
    // --------------------
    task automatic wbWrite(input logic [ADDR_W-1:0] addr, input logic [LETTER_W-1:0] data);
        @(posedge clk);
        wbCyc   <= 1'b1;
        wbStb   <= 1'b1;
        wbWe    <= 1'b1;
        wbAdr   <= addr;
        wbDatIn <= BUS_W'(data);
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
    endtask

    task automatic wbRead(input logic [ADDR_W-1:0] addr, output logic [BUS_W-1:0] data);
        @(posedge clk);
        wbCyc <= 1'b1;
        wbStb <= 1'b1;
        wbWe  <= 1'b0;
        wbAdr <= addr;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        data = wbDatOut;
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
    endtask

    task automatic pollStatus(output logic [BUS_W-1:0] s);
        do wbRead(ADDR_STATUS, s);
        while (s[ST_BUSY]);
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic modelGuess(input logic [LETTER_W-1:0] l);
        logic [WORD_LEN-1:0] hit;
        if (mRunning) begin
            for (int i = 0; i < WORD_LEN; i++) begin
                hit[i] = (mWord[i] == l);
            end
            if (hit != '0) begin
                mReveal = mReveal | hit;
                mWon    = &mReveal;
            end else begin
                mMiss++;
                mLost = (mMiss == MAX_MISTAKES);
            end
            mRunning = !(mWon || mLost);
        end
    endtask

    task automatic checkStatus(input logic [BUS_W-1:0] s);
        logic [BUS_W-1:0] e;
        e                         = '0;
        e[ST_WON]                 = mWon;
        e[ST_LOST]                = mLost;
        e[ST_MISS_HI:ST_MISS_LO]  = MISS_W'(mMiss);
        e[ST_MASK_HI:ST_MASK_LO]  = mReveal;
        checkValue("status", s, e);
        checkValue("revealed", BUS_W'(revealed), BUS_W'(mReveal));
        checkValue("mistakes", BUS_W'(mistakes), BUS_W'(mMiss));
        checkValue("won", BUS_W'(won), BUS_W'(mWon));
        checkValue("lost", BUS_W'(lost), BUS_W'(mLost));
        checkValue("busy", BUS_W'(busy), 0);
    endtask

    task automatic loadWord(input logic [WORD_LEN-1:0][LETTER_W-1:0] w);
        // the leftmost character of w becomes letter 0.
        for (int i = 0; i < WORD_LEN; i++) begin
            wbWrite(ADDR_W'(i), w[WORD_LEN-1-i]);
            if (!mRunning) begin
                mWord[i] = w[WORD_LEN-1-i];
            end
        end
    endtask

    task automatic startGame();
        wbWrite(ADDR_START, '0);
        mRunning = 1'b1;
        mReveal  = '0;
        mMiss    = 0;
        mWon     = 1'b0;
        mLost    = 1'b0;
    endtask

    task automatic guessAndCheck(input logic [LETTER_W-1:0] l);
        logic [BUS_W-1:0] s;
        wbWrite(ADDR_GUESS, l);
        modelGuess(l);
        pollStatus(s);
        checkStatus(s);
    endtask

    // 'z' is never part of a loaded word, so each one is a mistake.
    task automatic endGame();
        while (mRunning) guessAndCheck(8'h7a);
    endtask

    initial begin
        logic [BUS_W-1:0]    s;
        logic [LETTER_W-1:0] l;
        int                  n;
        seed     = 32'h9a64;
        errors   = 0;
        checks   = 0;
        clk      = 1'b0;
        nRst     = 1'b0;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        wbAdr    = '0;
        wbDatIn  = '0;
        mReveal  = '0;
        mMiss    = 0;
        mWon     = 1'b0;
        mLost    = 1'b0;
        mRunning = 1'b0;
        repeat (3) @(posedge clk);
        nRst <= 1'b1;

        wbRead(ADDR_STATUS, s);
        checkValue("status", s, '0);
        guessAndCheck(8'h61);

        for (int g = 0; g < NUM_GAMES; g++) begin
            loadWord(randWord());
            startGame();
            n = 0;
            while (mRunning && n < GUESS_CAP) begin
                guessAndCheck(pickGuess());
                n++;
            end
            endGame();
        end

        // --------------------
        // directed games
        // --------------------
        loadWord(randWord());
        startGame();
        for (int i = 0; i < WORD_LEN; i++) begin
            guessAndCheck(mWord[i]);
        end
        checkValue("won", BUS_W'(won), 1);
        checkValue("lost", BUS_W'(lost), 0);
        guessAndCheck(8'h7a);
        guessAndCheck(mWord[0]);

        loadWord(randWord());
        startGame();
        for (int i = 0; i < MAX_MISTAKES; i++) begin
            guessAndCheck(LETTER_W'(8'h71 + i));
        end
        checkValue("lost", BUS_W'(lost), 1);
        checkValue("mistakes", BUS_W'(mistakes), MAX_MISTAKES);
        guessAndCheck(8'h72);
        guessAndCheck(mWord[1]);

        // back-to-back guesses stall on the full buffer.
        loadWord(randWord());
        startGame();
        for (int i = 0; i < 8; i++) begin
            l = pickGuess();
            wbWrite(ADDR_GUESS, l);
            modelGuess(l);
        end
        pollStatus(s);
        checkStatus(s);
        endGame();

        loadWord("crane");
        startGame();
        guessAndCheck("c");
        loadWord("zzzzz");
        for (int i = 0; i < WORD_LEN; i++) begin
            guessAndCheck(mWord[i]);
        end
        checkValue("won", BUS_W'(won), 1);
        startGame();
        pollStatus(s);
        checkStatus(s);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

// File: hangman.f
source/hangmanPkg.sv
source/hangmanIf.sv
source/wbGuessPort.sv
source/gameLogic.sv
source/scoreKeeper.sv
source/hangmanTop.sv
verification/hangman_chk.sv
verification/hangmanTb.sv

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f hangman.f --top-module hangmanTb

# the simulation may stop early on a failed assertion, so its status is not used.
output="$(./obj_dir/VhangmanTb 2>&1)" || true
echo "$output"

if grep -q "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1
